//--- Bender.yml
package:
  name: beamformer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/beam_pkg.sv
      - hdl/weight_regs.sv
      - hdl/complex_weight_mult.sv
      - hdl/beam_combiner.sv
      - hdl/beamformer_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/clock_gen.sv
      - tb/beamformer_checker.sv
      - tb/beamformer_tb.sv

//--- hdl/beam_combiner.sv
//################################################
// stream control and channel sum for the beamformer
// owns the pipeline enable and the valid/last shift
// the channel sum lands in the output register
//################################################
`include "beam_params.svh"

module beam_combiner (
    input  logic                 clock,
    input  logic                 resetn,
    input  beam_pkg::chan_beat_t chan_re,
    input  beam_pkg::chan_beat_t chan_im,
    input  logic                 s_tvalid,
    input  logic                 s_tlast,
    input  logic                 m_tready,
    output logic                 s_tready,
    output logic                 enable,
    output beam_pkg::beat_t      m_tdata_re,
    output beam_pkg::beat_t      m_tdata_im,
    output logic                 m_tvalid,
    output logic                 m_tlast
);
    import beam_pkg::*;

    logic  take;
    logic  valid_s1;
    logic  valid_s2;
    logic  last_s1;
    logic  last_s2;
    beat_t sum_re;
    beat_t sum_im;

    // the whole pipeline moves unless a finished beat is waiting at the output
    assign enable   = !m_tvalid || m_tready;
    assign s_tready = enable;
    assign take     = s_tvalid && s_tready;

    // sum across channels wraps at sample width
    always_comb begin
        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            sum_re[s] = '0;
            sum_im[s] = '0;
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                sum_re[s] = sum_re[s] + chan_re[c][s];
                sum_im[s] = sum_im[s] + chan_im[c][s];
            end
        end
    end

    // valid and last follow the data through all three stages
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            m_tvalid <= 1'b0;
            last_s1  <= 1'b0;
            last_s2  <= 1'b0;
            m_tlast  <= 1'b0;
        end else if (enable) begin
            valid_s1 <= take;
            valid_s2 <= valid_s1;
            m_tvalid <= valid_s2;
            last_s1  <= s_tlast;
            last_s2  <= last_s1;
            m_tlast  <= last_s2;
        end
    end

    // stage 3, a bubble may load here but m_tvalid stays low for it
    always_ff @(posedge clock) begin
        if (enable) begin
            m_tdata_re <= sum_re;
            m_tdata_im <= sum_im;
        end
    end

endmodule

//--- hdl/beam_params.svh
//################################################
// widths, counts and scaling for the beamformer
// include wherever a width or count is needed
//################################################
`ifndef BEAM_PARAMS_SVH
`define BEAM_PARAMS_SVH

// one real or imaginary part of a sample
`define BEAM_SAMPLE_WIDTH 16
// one real or imaginary part of a channel weight
`define BEAM_WEIGHT_WIDTH 8
// complex samples per channel in each beat
`define BEAM_SAMPLES 4
// antenna channels summed into the beam
`define BEAM_CHANNELS 4
// a weight counts in units of 1/256, so each product drops this many bits
`define BEAM_WEIGHT_SHIFT 8

// AXI4-Lite register bus, one word per channel weight
`define BEAM_AXIL_ADDR_WIDTH 4
`define BEAM_AXIL_DATA_WIDTH 32

`endif

//--- hdl/beam_pkg.sv
//################################################
// shared datapath types for the beamformer
// modules name these through beam_pkg in ports
//################################################
`include "beam_params.svh"

package beam_pkg;

    // one signed real or imaginary part
    typedef logic signed [`BEAM_SAMPLE_WIDTH-1:0] sample_t;

    // one signed weight part
    typedef logic signed [`BEAM_WEIGHT_WIDTH-1:0] weight_t;

    // full width of a sample times a weight, before scaling
    typedef logic signed [`BEAM_SAMPLE_WIDTH+`BEAM_WEIGHT_WIDTH-1:0] product_t;

    // the real or the imaginary parts of one channel (or the beam) for one beat
    typedef sample_t [`BEAM_SAMPLES-1:0] beat_t;

    // the same parts for every channel at once, channel 0 in the low bits
    typedef beat_t [`BEAM_CHANNELS-1:0] chan_beat_t;

    // one weight part per channel
    typedef weight_t [`BEAM_CHANNELS-1:0] weight_bank_t;

endpackage

//--- hdl/beamformer_top.sv
//################################################
// four-channel narrowband receive beamformer
// input beats are weighted per channel and summed
// weights are set over the AXI4-Lite register port
//################################################
`include "beam_params.svh"

module beamformer_top (
    input  logic                                clock,
    input  logic                                resetn,
    input  beam_pkg::chan_beat_t                s_tdata_re,
    input  beam_pkg::chan_beat_t                s_tdata_im,
    input  logic                                s_tvalid,
    output logic                                s_tready,
    input  logic                                s_tlast,
    output beam_pkg::beat_t                     m_tdata_re,
    output beam_pkg::beat_t                     m_tdata_im,
    output logic                                m_tvalid,
    input  logic                                m_tready,
    output logic                                m_tlast,
    input  logic [`BEAM_AXIL_ADDR_WIDTH-1:0]    s_axil_awaddr,
    input  logic                                s_axil_awvalid,
    output logic                                s_axil_awready,
    input  logic [`BEAM_AXIL_DATA_WIDTH-1:0]    s_axil_wdata,
    input  logic [`BEAM_AXIL_DATA_WIDTH/8-1:0]  s_axil_wstrb,
    input  logic                                s_axil_wvalid,
    output logic                                s_axil_wready,
    output logic [1:0]                          s_axil_bresp,
    output logic                                s_axil_bvalid,
    input  logic                                s_axil_bready,
    input  logic [`BEAM_AXIL_ADDR_WIDTH-1:0]    s_axil_araddr,
    input  logic                                s_axil_arvalid,
    output logic                                s_axil_arready,
    output logic [`BEAM_AXIL_DATA_WIDTH-1:0]    s_axil_rdata,
    output logic [1:0]                          s_axil_rresp,
    output logic                                s_axil_rvalid,
    input  logic                                s_axil_rready
);
    import beam_pkg::*;

    weight_bank_t w_re;
    weight_bank_t w_im;
    chan_beat_t   chan_re;
    chan_beat_t   chan_im;
    logic         enable;

    weight_regs weight_regs_i (
        .clock          (clock),
        .resetn         (resetn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .w_re           (w_re),
        .w_im           (w_im)
    );

    // one multiplier per antenna channel, all stepped by the same enable
    for (genvar c = 0; c < `BEAM_CHANNELS; c++) begin : g_chan
        complex_weight_mult complex_weight_mult_i (
            .clock  (clock),
            .enable (enable),
            .in_re  (s_tdata_re[c]),
            .in_im  (s_tdata_im[c]),
            .w_re   (w_re[c]),
            .w_im   (w_im[c]),
            .out_re (chan_re[c]),
            .out_im (chan_im[c])
        );
    end

    beam_combiner beam_combiner_i (
        .clock      (clock),
        .resetn     (resetn),
        .chan_re    (chan_re),
        .chan_im    (chan_im),
        .s_tvalid   (s_tvalid),
        .s_tlast    (s_tlast),
        .m_tready   (m_tready),
        .s_tready   (s_tready),
        .enable     (enable),
        .m_tdata_re (m_tdata_re),
        .m_tdata_im (m_tdata_im),
        .m_tvalid   (m_tvalid),
        .m_tlast    (m_tlast)
    );

endmodule

//--- hdl/complex_weight_mult.sv
//################################################
// complex weight of one channel's beat, two stages
// stage 1 holds scaled products, stage 2 the result
// advances only while the combiner's enable is high
//################################################
`include "beam_params.svh"

module complex_weight_mult (
    input  logic              clock,
    input  logic              enable,
    input  beam_pkg::beat_t   in_re,
    input  beam_pkg::beat_t   in_im,
    input  beam_pkg::weight_t w_re,
    input  beam_pkg::weight_t w_im,
    output beam_pkg::beat_t   out_re,
    output beam_pkg::beat_t   out_im
);
    import beam_pkg::*;

    // one guard bit so the difference or sum of two parts cannot overflow
    typedef logic signed [`BEAM_SAMPLE_WIDTH:0] wide_t;

    beat_t rr_q;
    beat_t ii_q;
    beat_t ri_q;
    beat_t ir_q;

    // full product, arithmetic shift back to sample scale, keep the low bits
    function automatic sample_t scale(input sample_t x, input weight_t w);
        product_t p;
        p = product_t'(x) * product_t'(w);
        return sample_t'(p >>> `BEAM_WEIGHT_SHIFT);
    endfunction

    // halving the wide result brings it back into sample range
    function automatic sample_t halve(input wide_t x);
        return sample_t'(x >>> 1);
    endfunction

    // stage 1, weights are sampled here together with the beat
    always_ff @(posedge clock) begin
        if (enable) begin
            for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                rr_q[s] <= scale(in_re[s], w_re);
                ii_q[s] <= scale(in_im[s], w_im);
                ri_q[s] <= scale(in_re[s], w_im);
                ir_q[s] <= scale(in_im[s], w_re);
            end
        end
    end

    // stage 2, (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    always_ff @(posedge clock) begin
        if (enable) begin
            for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                out_re[s] <= halve(wide_t'(rr_q[s]) - wide_t'(ii_q[s]));
                out_im[s] <= halve(wide_t'(ri_q[s]) + wide_t'(ir_q[s]));
            end
        end
    end

endmodule

//--- hdl/weight_regs.sv
//################################################
// AXI4-Lite register block for the channel weights
// word n holds channel n: imag in 15..8, real in 7..0
// weights drive the multipliers continuously
//################################################
`include "beam_params.svh"

module weight_regs (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic [`BEAM_AXIL_ADDR_WIDTH-1:0]    s_axil_awaddr,
    input  logic                                s_axil_awvalid,
    output logic                                s_axil_awready,
    input  logic [`BEAM_AXIL_DATA_WIDTH-1:0]    s_axil_wdata,
    input  logic [`BEAM_AXIL_DATA_WIDTH/8-1:0]  s_axil_wstrb,
    input  logic                                s_axil_wvalid,
    output logic                                s_axil_wready,
    output logic [1:0]                          s_axil_bresp,
    output logic                                s_axil_bvalid,
    input  logic                                s_axil_bready,
    input  logic [`BEAM_AXIL_ADDR_WIDTH-1:0]    s_axil_araddr,
    input  logic                                s_axil_arvalid,
    output logic                                s_axil_arready,
    output logic [`BEAM_AXIL_DATA_WIDTH-1:0]    s_axil_rdata,
    output logic [1:0]                          s_axil_rresp,
    output logic                                s_axil_rvalid,
    input  logic                                s_axil_rready,
    output beam_pkg::weight_bank_t              w_re,
    output beam_pkg::weight_bank_t              w_im
);

    // byte distance between consecutive channel words
    localparam int WORD_BYTES = `BEAM_AXIL_DATA_WIDTH / 8;

    logic write_take;
    logic read_take;

    // a write needs address and data together and no response still waiting
    assign write_take = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign read_take  = s_axil_arvalid && !s_axil_rvalid;

    assign s_axil_awready = write_take;
    assign s_axil_wready  = write_take;
    assign s_axil_arready = read_take;

    // every access completes, unmapped ones included
    assign s_axil_bresp = 2'b00;
    assign s_axil_rresp = 2'b00;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            w_re          <= '0;
            w_im          <= '0;
            s_axil_bvalid <= 1'b0;
        end else begin
            if (write_take) begin
                // only an exact word address selects a channel, anything else is dropped
                for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                    if (s_axil_awaddr == c * WORD_BYTES) begin
                        if (s_axil_wstrb[0]) begin
                            w_re[c] <= s_axil_wdata[`BEAM_WEIGHT_WIDTH-1:0];
                        end
                        if (s_axil_wstrb[1]) begin
                            w_im[c] <= s_axil_wdata[2*`BEAM_WEIGHT_WIDTH-1:`BEAM_WEIGHT_WIDTH];
                        end
                    end
                end
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    // the response flag holds until the master takes the data
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s_axil_rvalid <= 1'b0;
        end else if (read_take) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    // readback data only changes when a new read is taken
    always_ff @(posedge clock) begin
        if (read_take) begin
            s_axil_rdata <= '0;
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                if (s_axil_araddr == c * WORD_BYTES) begin
                    // upper bits fill with zero from the unsigned concatenation
                    s_axil_rdata <= {w_im[c], w_re[c]};
                end
            end
        end
    end

endmodule

//--- project.f
+incdir+hdl
hdl/beam_pkg.sv
hdl/weight_regs.sv
hdl/complex_weight_mult.sv
hdl/beam_combiner.sv
hdl/beamformer_top.sv
tb/clock_gen.sv
tb/beamformer_checker.sv
tb/beamformer_tb.sv

//--- tb/beamformer_checker.sv
//################################################
// protocol assertions for the beamformer
// bound into beamformer_top, counts its own failures
//################################################

module beamformer_checker (
    input logic            clock,
    input logic            resetn,
    input beam_pkg::beat_t m_tdata_re,
    input beam_pkg::beat_t m_tdata_im,
    input logic            m_tvalid,
    input logic            m_tready,
    input logic            m_tlast,
    input logic            s_axil_bvalid,
    input logic            s_axil_bready,
    input logic            s_axil_rvalid,
    input logic            s_axil_rready
);

    // read by the testbench at the end of the run
    int failures = 0;

    // synchronous reset clears the output valid on the following edge
    assert property (@(posedge clock) !resetn |=> !m_tvalid)
        else begin
            $error("m_tvalid high while resetn was low");
            failures++;
        end

    // a stalled output beat must not change or vanish
    assert property (@(posedge clock) disable iff (!resetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata_re)
            && $stable(m_tdata_im) && $stable(m_tlast))
        else begin
            $error("output beat changed or dropped while stalled");
            failures++;
        end

    // write response holds until bready
    assert property (@(posedge clock) disable iff (!resetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else begin
            $error("bvalid dropped before bready");
            failures++;
        end

    // read data holds until rready
    assert property (@(posedge clock) disable iff (!resetn)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else begin
            $error("rvalid dropped before rready");
            failures++;
        end

endmodule

bind beamformer_top beamformer_checker beamformer_checker_i (
    .clock         (clock),
    .resetn        (resetn),
    .m_tdata_re    (m_tdata_re),
    .m_tdata_im    (m_tdata_im),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .m_tlast       (m_tlast),
    .s_axil_bvalid (s_axil_bvalid),
    .s_axil_bready (s_axil_bready),
    .s_axil_rvalid (s_axil_rvalid),
    .s_axil_rready (s_axil_rready)
);

//--- tb/beamformer_tb.sv
//################################################
// testbench for the four-channel beamformer
// sets weights over AXI4-Lite, streams beats in and
// scores every output beat against a reference model
//################################################
`include "beam_params.svh"

module beamformer_tb;
    import beam_pkg::*;

    // about 300 beats at up to 4x stall, with slack for the register traffic
    localparam int RUN_BEATS      = 300;
    localparam int TIMEOUT_CYCLES = RUN_BEATS * 4 * 16 + 800;

    logic                               clock;
    logic                               resetn;
    chan_beat_t                         s_tdata_re;
    chan_beat_t                         s_tdata_im;
    logic                               s_tvalid;
    logic                               s_tready;
    logic                               s_tlast;
    beat_t                              m_tdata_re;
    beat_t                              m_tdata_im;
    logic                               m_tvalid;
    logic                               m_tready;
    logic                               m_tlast;
    logic [`BEAM_AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr;
    logic                               s_axil_awvalid;
    logic                               s_axil_awready;
    logic [`BEAM_AXIL_DATA_WIDTH-1:0]   s_axil_wdata;
    logic [`BEAM_AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb;
    logic                               s_axil_wvalid;
    logic                               s_axil_wready;
    logic [1:0]                         s_axil_bresp;
    logic                               s_axil_bvalid;
    logic                               s_axil_bready;
    logic [`BEAM_AXIL_ADDR_WIDTH-1:0]   s_axil_araddr;
    logic                               s_axil_arvalid;
    logic                               s_axil_arready;
    logic [`BEAM_AXIL_DATA_WIDTH-1:0]   s_axil_rdata;
    logic [1:0]                         s_axil_rresp;
    logic                               s_axil_rvalid;
    logic                               s_axil_rready;

    // separate generators so the stream data does not depend on m_tready draws
    logic [31:0]  data_lfsr;
    logic [31:0]  ready_lfsr;
    logic         ready_random;
    // weights as written, which is what the reference applies
    weight_bank_t model_w_re;
    weight_bank_t model_w_im;
    // {tlast, imag beat, real beat} per accepted input beat
    logic [128:0] expected_q[$];
    int           errors = 0;
    int           beats_sent = 0;
    int           beats_checked = 0;
    int           cycle = 0;

    clock_gen clock_gen_i (
        .clock  (clock),
        .resetn (resetn)
    );

    beamformer_top beamformer_top_i (.*);

    // Fibonacci LFSR with taps 32 22 2 1, one step for each bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            bits  = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // expected beam for one beat as {imag, real}
    function automatic logic [127:0] reference_beam(input chan_beat_t re, input chan_beat_t im,
                                                    input weight_bank_t wr, input weight_bank_t wi);
        beat_t   beam_re;
        beat_t   beam_im;
        int      acc_re;
        int      acc_im;
        sample_t rr;
        sample_t ii;
        sample_t ri;
        sample_t ir;
        for (int s = 0; s < `BEAM_SAMPLES; s++) begin
            acc_re = 0;
            acc_im = 0;
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                // each product is shifted back to sample scale and cut to 16 bits
                rr = sample_t'((int'(re[c][s]) * int'(wr[c])) >>> `BEAM_WEIGHT_SHIFT);
                ii = sample_t'((int'(im[c][s]) * int'(wi[c])) >>> `BEAM_WEIGHT_SHIFT);
                ri = sample_t'((int'(re[c][s]) * int'(wi[c])) >>> `BEAM_WEIGHT_SHIFT);
                ir = sample_t'((int'(im[c][s]) * int'(wr[c])) >>> `BEAM_WEIGHT_SHIFT);
                // the halved channel result always fits in 16 bits
                acc_re += (int'(rr) - int'(ii)) >>> 1;
                acc_im += (int'(ri) + int'(ir)) >>> 1;
            end
            // the sum wraps to sample width
            beam_re[s] = sample_t'(acc_re);
            beam_im[s] = sample_t'(acc_im);
        end
        return {beam_im, beam_re};
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // every accepted beat is pushed with the weights in force at stage 1
    always @(posedge clock) begin
        if (resetn && s_tvalid && s_tready) begin
            expected_q.push_back({s_tlast,
                reference_beam(s_tdata_re, s_tdata_im, model_w_re, model_w_im)});
        end
    end

    // output beats must come out in input order, each exactly once
    always @(posedge clock) begin
        logic [128:0] expected;
        if (resetn && m_tvalid && m_tready) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("output beat at %0t with no input beat outstanding", $time);
            end else begin
                expected = expected_q.pop_front();
                check_value("beam data", {m_tdata_im, m_tdata_re}, expected[127:0]);
                check_value("beam tlast", 128'(m_tlast), 128'(expected[128]));
                beats_checked++;
            end
        end
    end

    // output back-pressure, one random bit per cycle while enabled
    always @(posedge clock) begin
        #1;
        if (ready_random) begin
            m_tready = lfsr_take(ready_lfsr, 1) != 0;
        end else begin
            m_tready = 1'b1;
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic axil_write(input logic [`BEAM_AXIL_ADDR_WIDTH-1:0] addr,
                              input logic [`BEAM_AXIL_DATA_WIDTH-1:0] data);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = '1;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        @(posedge clock);
        // address and data are offered together, so both must be taken on one edge
        while (!(s_axil_awready && s_axil_wready)) @(posedge clock);
        #1;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(posedge clock);
        while (!s_axil_bvalid) @(posedge clock);
        check_value("write response", 128'(s_axil_bresp), 128'(0));
        #1;
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [`BEAM_AXIL_ADDR_WIDTH-1:0] addr,
                             output logic [`BEAM_AXIL_DATA_WIDTH-1:0] data);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        @(posedge clock);
        while (!s_axil_arready) @(posedge clock);
        #1;
        s_axil_arvalid = 1'b0;
        @(posedge clock);
        while (!s_axil_rvalid) @(posedge clock);
        data = s_axil_rdata;
        check_value("read response", 128'(s_axil_rresp), 128'(0));
        #1;
        s_axil_rready = 1'b0;
    endtask

    // real weight in bits 7..0, imaginary in 15..8
    task automatic set_weight(input int ch, input logic [31:0] data);
        axil_write(`BEAM_AXIL_ADDR_WIDTH'(ch * 4), data);
        model_w_re[ch] = data[7:0];
        model_w_im[ch] = data[15:8];
    endtask

    // holds the beat until the DUT takes it, returns just after that edge
    task automatic send_beat(input chan_beat_t re, input chan_beat_t im, input logic last);
        s_tdata_re = re;
        s_tdata_im = im;
        s_tlast    = last;
        s_tvalid   = 1'b1;
        @(posedge clock);
        while (!s_tready) @(posedge clock);
        #1;
        s_tvalid = 1'b0;
        beats_sent++;
    endtask

    task automatic random_beat(output chan_beat_t re, output chan_beat_t im);
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                re[c][s] = lfsr_take(data_lfsr, 16);
                im[c][s] = lfsr_take(data_lfsr, 16);
            end
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        chan_beat_t  re;
        chan_beat_t  im;
        logic [31:0] word;
        logic [31:0] readback;
        int          accept_cycle;
        int          assert_errors;

        data_lfsr      = 32'h8826;
        ready_lfsr     = 32'h8826;
        ready_random   = 1'b0;
        model_w_re     = '0;
        model_w_im     = '0;
        s_tdata_re     = '0;
        s_tdata_im     = '0;
        s_tvalid       = 1'b0;
        s_tlast        = 1'b0;
        m_tready       = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;

        // resetn rises one unit after an edge, so this is already a drive point
        wait (resetn);
        check_value("m_tvalid after reset", 128'(m_tvalid), 128'(0));
        check_value("s_tready after reset", 128'(s_tready), 128'(1));
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            axil_read(`BEAM_AXIL_ADDR_WIDTH'(c * 4), readback);
            check_value("weight after reset", 128'(readback), 128'(0));
        end

        // full words go in, only the two weight bytes come back
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            word = lfsr_take(data_lfsr, 32);
            set_weight(c, word);
            axil_read(`BEAM_AXIL_ADDR_WIDTH'(c * 4), readback);
            check_value("weight readback", 128'(readback), 128'(word & 32'h0000_ffff));
        end
        // 0x6 is not a word address of any channel
        axil_write(4'h6, 32'h0000_5a5a);
        axil_read(4'h6, readback);
        check_value("unmapped readback", 128'(readback), 128'(0));
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            axil_read(`BEAM_AXIL_ADDR_WIDTH'(c * 4), readback);
            check_value("weight after unmapped write", 128'(readback),
                        128'({model_w_im[c], model_w_re[c]}));
        end

        // channel 0 alone at a quarter of full scale
        set_weight(0, 32'h0000_0040);
        for (int c = 1; c < `BEAM_CHANNELS; c++) begin
            set_weight(c, 32'h0);
        end
        for (int b = 0; b < 4; b++) begin
            for (int c = 0; c < `BEAM_CHANNELS; c++) begin
                for (int s = 0; s < `BEAM_SAMPLES; s++) begin
                    case (b)
                        0: re[c][s] = 16'sh8000;
                        1: re[c][s] = 16'sh7fff;
                        2: re[c][s] = sample_t'((c * 4 + s) * 2000 - 16000);
                        default: re[c][s] = lfsr_take(data_lfsr, 16);
                    endcase
                    // beat 0 has both parts at full-scale negative
                    im[c][s] = b[0] ? ~re[c][s] : -re[c][s];
                end
            end
            send_beat(re, im, b == 3);
        end
        wait_drain();

        // all channels weighted, back-to-back beats
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            set_weight(c, lfsr_take(data_lfsr, 16));
        end
        repeat (200) begin
            random_beat(re, im);
            send_beat(re, im, lfsr_take(data_lfsr, 1) != 0);
        end
        wait_drain();

        // random output stalls and input gaps of up to three cycles
        for (int c = 0; c < `BEAM_CHANNELS; c++) begin
            set_weight(c, lfsr_take(data_lfsr, 16));
        end
        ready_random = 1'b1;
        repeat (80) begin
            random_beat(re, im);
            send_beat(re, im, lfsr_take(data_lfsr, 1) != 0);
            idle(lfsr_take(data_lfsr, 2));
        end
        wait_drain();
        ready_random = 1'b0;
        idle(2);

        // with the pipeline idle the beat is taken at the next edge, and m_tvalid
        // rises at the third edge counting that one, one edge per register stage
        random_beat(re, im);
        accept_cycle = cycle;
        send_beat(re, im, 1'b1);
        while (!m_tvalid) begin
            idle(1);
        end
        check_value("latency in cycles", 128'(cycle - accept_cycle), 128'(3));
        wait_drain();
        idle(4);

        check_value("beats out against beats in", 128'(beats_checked), 128'(beats_sent));
        assert_errors = beamformer_top_i.beamformer_checker_i.failures;
        $display("errors: %0d check, %0d assertion; beats checked: %0d", errors, assert_errors,
                 beats_checked);
        if (errors == 0 && assert_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb/clock_gen.sv
//################################################
// testbench clock and reset for the beamformer
// clock period is 8, resetn held low 10 cycles
//################################################

module clock_gen (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // release lands just after an edge, like every other driven input
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        resetn = 1'b1;
    end

endmodule
